//--- source/phold_cfg.svh
`ifndef PHOLD_CFG_SVH
`define PHOLD_CFG_SVH

// event timestamp and LP id widths
`define PHOLD_TIME_WID 16
`define PHOLD_NB_LPID 6

// processing cores
`define PHOLD_NUM_CORE 4
`define PHOLD_NB_COREID 2

// event queue size and its occupancy counter width
`define PHOLD_QUEUE_DEPTH 16
`define PHOLD_NB_CNT 5

// random number generator width and start value (must be nonzero)
`define PHOLD_NB_RAND 24
`define PHOLD_RNG_SEED 24'h5A3C71

// cycles a core spends on one event before offering the new one
`define PHOLD_CORE_DELAY 4

// random bits added to the timestamp of each new event
`define PHOLD_NB_TIME_INC 3

`endif

//--- source/phold_pkg.sv
`include "phold_cfg.svh"

package phold_pkg;

   // simulation timestamp
   typedef logic [`PHOLD_TIME_WID-1:0] sim_time_t;

   // logical process id
   typedef logic [`PHOLD_NB_LPID-1:0] lp_id_t;

   // index of a processing core
   typedef logic [`PHOLD_NB_COREID-1:0] core_id_t;

   // event message, LP id above the timestamp
   typedef logic [`PHOLD_NB_LPID+`PHOLD_TIME_WID-1:0] event_t;

   // raw LFSR word
   typedef logic [`PHOLD_NB_RAND-1:0] rand_t;

   // run control FSM
   typedef enum logic [2:0] {
      IDLE,
      INIT,
      READY,
      RUNNING,
      FINISHED
   } run_state_t;

   // per core FSM
   typedef enum logic [1:0] {FREE, BUSY, HOLD} core_state_t;

endpackage

//--- source/rr_arbiter.sv
`timescale 1ns/1ns

module rr_arbiter #(
   parameter int NR = 4
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [NR-1:0]        req,
   input  logic                 advance,
   output logic                 gnt_vld,
   output phold_pkg::core_id_t  gnt_id,
   output logic [NR-1:0]        gnt_onehot
);

   phold_pkg::core_id_t ptr;
   phold_pkg::core_id_t win_id;
   phold_pkg::core_id_t idx;
   logic win_vld;
   logic hold;

   // first requester at or after the priority pointer
   always_comb begin
      win_vld = 1'b0;
      win_id = ptr;
      for (int i = 0; i < NR; i++) begin
         idx = phold_pkg::core_id_t'((int'(ptr) + i) % NR);
         if (!win_vld && req[idx]) begin
            win_vld = 1'b1;
            win_id = idx;
         end
      end
   end

   // keep the grant while its owner still asks and nobody used it
   assign hold = gnt_vld && req[gnt_id] && !advance;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gnt_vld <= 1'b0;
         gnt_id <= '0;
         ptr <= '0;
      end else begin
         if (!hold) begin
            gnt_vld <= win_vld;
            gnt_id <= win_id;
         end
         // rotate past the winner once its grant is consumed
         if (advance && gnt_vld) begin
            ptr <= (int'(gnt_id) == NR - 1) ? '0 : gnt_id + 1'b1;
         end
      end
   end

   always_comb begin
      gnt_onehot = '0;
      if (gnt_vld)
         gnt_onehot[gnt_id] = 1'b1;
   end

endmodule

//--- source/event_queue.sv
`timescale 1ns/1ns
`include "phold_cfg.svh"

module event_queue (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               flush,
   input  logic               enq,
   input  logic               deq,
   input  phold_pkg::event_t  in_event,
   output phold_pkg::event_t  head_event,
   output logic               full,
   output logic               empty
);

   localparam int DEPTH = `PHOLD_QUEUE_DEPTH;
   localparam int TW = `PHOLD_TIME_WID;

   phold_pkg::event_t ents [DEPTH];
   logic [`PHOLD_NB_CNT-1:0] cnt;
   logic [DEPTH-1:0] vld;
   logic [DEPTH-1:0] after;
   phold_pkg::sim_time_t in_time;
   logic do_enq;
   logic do_deq;

   assign in_time = in_event[TW-1:0];

   assign full = (cnt == DEPTH);
   assign empty = (cnt == 0);

   // enqueue has priority, never both in the same slot anyway
   assign do_enq = enq && !full;
   assign do_deq = deq && !empty && !enq;

   // entries are valid from the head down to cnt
   // after[] marks the entries that must move down for the new event,
   // strictly later timestamps only so equal times stay in arrival order
   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         vld[i] = (i < cnt);
         after[i] = !vld[i] || (in_time < ents[i][TW-1:0]);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         cnt <= '0;
      else if (flush)
         cnt <= '0;
      else if (do_enq)
         cnt <= cnt + 1'b1;
      else if (do_deq)
         cnt <= cnt - 1'b1;
   end

   // sorted storage
   always_ff @(posedge clk) begin
      if (do_enq) begin
         if (after[0])
            ents[0] <= in_event;
         for (int i = 1; i < DEPTH; i++) begin
            if (after[i]) begin
               // first later entry takes the new event, the rest shift down
               if (!after[i-1])
                  ents[i] <= in_event;
               else
                  ents[i] <= ents[i-1];
            end
         end
      end else if (do_deq) begin
         for (int i = 0; i < DEPTH - 1; i++) begin
            ents[i] <= ents[i+1];
         end
      end
   end

   assign head_event = ents[0];

endmodule

//--- source/lfsr_rng.sv
`timescale 1ns/1ns
`include "phold_cfg.svh"

module lfsr_rng (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              next,
   output phold_pkg::rand_t  rnd
);

   phold_pkg::rand_t sr;
   logic fb;

   // x^24 + x^23 + x^22 + x^17 + 1, maximal length
   assign fb = sr[23] ^ sr[22] ^ sr[21] ^ sr[16];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         sr <= `PHOLD_RNG_SEED;
      else if (next)
         sr <= {sr[`PHOLD_NB_RAND-2:0], fb};
   end

   assign rnd = sr;

endmodule

//--- source/phold_core.sv
`timescale 1ns/1ns
`include "phold_cfg.svh"

module phold_core (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  flush,
   input  logic                  event_valid,
   input  phold_pkg::event_t     cur_event,
   input  phold_pkg::rand_t      random_in,
   input  phold_pkg::lp_id_t     lp_mask,
   input  logic                  ack,
   output logic                  ready,
   output logic                  new_event_ready,
   output phold_pkg::event_t     out_event,
   output logic                  active,
   output phold_pkg::sim_time_t  cur_time
);

   localparam int TW = `PHOLD_TIME_WID;
   localparam int LW = `PHOLD_NB_LPID;
   localparam int DLY = `PHOLD_CORE_DELAY;
   localparam int CW = $clog2(DLY + 1);
   localparam int INC_W = `PHOLD_NB_TIME_INC;

   phold_pkg::core_state_t state;
   logic [CW-1:0] dly_cnt;
   phold_pkg::lp_id_t ev_lp;
   phold_pkg::lp_id_t nxt_lp;
   phold_pkg::sim_time_t ev_time;
   phold_pkg::sim_time_t inc;
   phold_pkg::sim_time_t nxt_time;
   phold_pkg::sim_time_t time_q;
   phold_pkg::event_t out_q;

   assign ev_lp = cur_event[TW +: LW];
   assign ev_time = cur_event[TW-1:0];

   // low bits pick the LP offset, the next few the time step
   assign inc = phold_pkg::sim_time_t'(random_in[LW +: INC_W]);
   assign nxt_lp = (ev_lp + random_in[LW-1:0]) & lp_mask;
   assign nxt_time = ev_time + inc + 1'b1;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= phold_pkg::FREE;
         dly_cnt <= '0;
      end else if (flush) begin
         state <= phold_pkg::FREE;
         dly_cnt <= '0;
      end else begin
         case (state)
            phold_pkg::FREE:
               if (event_valid) begin
                  state <= phold_pkg::BUSY;
                  dly_cnt <= CW'(DLY - 1);
               end
            // DLY cycles of processing
            phold_pkg::BUSY:
               if (dly_cnt == '0)
                  state <= phold_pkg::HOLD;
               else
                  dly_cnt <= dly_cnt - 1'b1;
            phold_pkg::HOLD:
               if (ack)
                  state <= phold_pkg::FREE;
            default:
               state <= phold_pkg::FREE;
         endcase
      end
   end

   // event payload, captured at acceptance
   always_ff @(posedge clk) begin
      if (state == phold_pkg::FREE && event_valid) begin
         time_q <= ev_time;
         out_q <= {nxt_lp, nxt_time};
      end
   end

   assign ready = (state == phold_pkg::FREE);
   assign new_event_ready = (state == phold_pkg::HOLD);
   assign active = (state != phold_pkg::FREE);
   assign cur_time = time_q;
   assign out_event = out_q;

endmodule

//--- source/gvt_tracker.sv
`timescale 1ns/1ns
`include "phold_cfg.svh"

module gvt_tracker (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        flush,
   input  logic                        running,
   input  logic                        q_empty,
   input  phold_pkg::sim_time_t        head_time,
   input  logic [`PHOLD_NUM_CORE-1:0]  core_active,
   input  phold_pkg::sim_time_t        core_time_0,
   input  phold_pkg::sim_time_t        core_time_1,
   input  phold_pkg::sim_time_t        core_time_2,
   input  phold_pkg::sim_time_t        core_time_3,
   output phold_pkg::sim_time_t        gvt
);

   localparam int NC = `PHOLD_NUM_CORE;

   phold_pkg::sim_time_t times [NC];
   phold_pkg::sim_time_t min_c;
   phold_pkg::sim_time_t min_q;
   phold_pkg::sim_time_t gvt_q;

   assign times[0] = core_time_0;
   assign times[1] = core_time_1;
   assign times[2] = core_time_2;
   assign times[3] = core_time_3;

   // all-ones when no event exists anywhere
   always_comb begin
      min_c = '1;
      if (!q_empty)
         min_c = head_time;
      for (int i = 0; i < NC; i++) begin
         if (core_active[i] && times[i] < min_c)
            min_c = times[i];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         min_q <= '1;
      else
         min_q <= min_c;
   end

   // GVT follows the minimum only during a run
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         gvt_q <= '0;
      else if (flush)
         gvt_q <= '0;
      else if (running)
         gvt_q <= min_q;
   end

   assign gvt = gvt_q;

endmodule

//--- source/phold_top.sv
`timescale 1ns/1ns
`include "phold_cfg.svh"

module phold_top (
   input  logic                  clk,
   input  logic                  rst_n,
   input  phold_pkg::sim_time_t  sim_end,
   input  logic [7:0]            num_init_events,
   input  phold_pkg::lp_id_t     lp_mask,
   output phold_pkg::sim_time_t  gvt,
   output logic                  rtn_vld,
   output logic                  running,
   output logic [63:0]           total_cycles,
   output logic                  disp_vld,
   output phold_pkg::lp_id_t     disp_lp,
   output phold_pkg::sim_time_t  disp_time
);

   localparam int NC = `PHOLD_NUM_CORE;
   localparam int TW = `PHOLD_TIME_WID;
   localparam int LW = `PHOLD_NB_LPID;

   phold_pkg::run_state_t state;
   phold_pkg::run_state_t state_nxt;
   logic [8:0] init_cnt;
   logic init_done;
   logic q_busy;
   logic q_full;
   logic q_empty;
   logic enq_init;
   logic enq_core;
   logic enq;
   logic deq;
   logic flush;
   phold_pkg::event_t enq_event;
   phold_pkg::event_t head_event;
   phold_pkg::rand_t rnd;
   logic disp_gnt_vld;
   logic [NC-1:0] disp_onehot;
   logic coll_gnt_vld;
   phold_pkg::core_id_t coll_id;
   logic [NC-1:0] coll_onehot;
   logic [NC-1:0] core_ready;
   logic [NC-1:0] core_new_rdy;
   logic [NC-1:0] core_active;
   phold_pkg::event_t core_out [NC];
   phold_pkg::sim_time_t core_time [NC];

   // run control
   always_comb begin
      state_nxt = state;
      case (state)
         phold_pkg::IDLE:     state_nxt = phold_pkg::INIT;
         phold_pkg::INIT:     if (init_done) state_nxt = phold_pkg::READY;
         phold_pkg::READY:    state_nxt = phold_pkg::RUNNING;
         phold_pkg::RUNNING:  if (gvt > sim_end) state_nxt = phold_pkg::FINISHED;
         phold_pkg::FINISHED: state_nxt = phold_pkg::IDLE;
         default:             state_nxt = phold_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= phold_pkg::IDLE;
         init_cnt <= '0;
         q_busy <= 1'b0;
         total_cycles <= '0;
      end else begin
         state <= state_nxt;
         init_cnt <= (state == phold_pkg::INIT) ? init_cnt + 1'b1 : '0;
         // each queue operation blocks the next cycle
         q_busy <= enq || deq;
         if (state == phold_pkg::IDLE && state_nxt == phold_pkg::INIT)
            total_cycles <= '0;
         else if (state == phold_pkg::RUNNING)
            total_cycles <= total_cycles + 1'b1;
      end
   end

   assign running = (state == phold_pkg::RUNNING);
   assign rtn_vld = (state == phold_pkg::FINISHED);
   assign flush = (state == phold_pkg::FINISHED);

   // one start-up insertion every other INIT cycle
   assign init_done = (init_cnt == {num_init_events, 1'b0});
   assign enq_init = (state == phold_pkg::INIT) && !q_busy && !init_done;

   // slot rule: collected events first, then dispatch
   assign enq_core = running && !q_busy && coll_gnt_vld && !q_full;
   assign enq = enq_init || enq_core;
   assign deq = running && !q_busy && !enq_core && !q_empty && disp_gnt_vld;

   assign enq_event = (state == phold_pkg::INIT) ?
                      {init_cnt[1 +: LW] & lp_mask, {TW{1'b0}}} : core_out[coll_id];

   // observation of each dispatched event
   assign disp_vld = deq;
   assign disp_lp = head_event[TW +: LW];
   assign disp_time = head_event[TW-1:0];

   event_queue u_queue (
      .clk        (clk),
      .rst_n      (rst_n),
      .flush      (flush),
      .enq        (enq),
      .deq        (deq),
      .in_event   (enq_event),
      .head_event (head_event),
      .full       (q_full),
      .empty      (q_empty)
   );

   rr_arbiter #(.NR(NC)) dispatch_arb (
      .clk        (clk),
      .rst_n      (rst_n),
      .req        (core_ready),
      .advance    (deq),
      .gnt_vld    (disp_gnt_vld),
      .gnt_id     (),
      .gnt_onehot (disp_onehot)
   );

   rr_arbiter #(.NR(NC)) collect_arb (
      .clk        (clk),
      .rst_n      (rst_n),
      .req        (core_new_rdy),
      .advance    (enq_core),
      .gnt_vld    (coll_gnt_vld),
      .gnt_id     (coll_id),
      .gnt_onehot (coll_onehot)
   );

   lfsr_rng u_rng (
      .clk   (clk),
      .rst_n (rst_n),
      .next  (deq),
      .rnd   (rnd)
   );

   for (genvar g = 0; g < NC; g++) begin : gen_core
      phold_core u_core (
         .clk             (clk),
         .rst_n           (rst_n),
         .flush           (flush),
         .event_valid     (deq && disp_onehot[g]),
         .cur_event       (head_event),
         .random_in       (rnd),
         .lp_mask         (lp_mask),
         .ack             (enq_core && coll_onehot[g]),
         .ready           (core_ready[g]),
         .new_event_ready (core_new_rdy[g]),
         .out_event       (core_out[g]),
         .active          (core_active[g]),
         .cur_time        (core_time[g])
      );
   end

   gvt_tracker u_gvt (
      .clk         (clk),
      .rst_n       (rst_n),
      .flush       (flush),
      .running     (running),
      .q_empty     (q_empty),
      .head_time   (head_event[TW-1:0]),
      .core_active (core_active),
      .core_time_0 (core_time[0]),
      .core_time_1 (core_time[1]),
      .core_time_2 (core_time[2]),
      .core_time_3 (core_time[3]),
      .gvt         (gvt)
   );

endmodule

//--- tb/phold_tb.sv
`timescale 1ns/1ns

module phold_tb;

   // four runs of up to ~104 time units, ~16 events per unit,
   // each event 2 queue cycles plus the core delay, with margin
   localparam int TIMEOUT_CYCLES = 60000;

   logic clk;
   logic rst_n;
   phold_pkg::sim_time_t sim_end;
   logic [7:0] num_init_events;
   phold_pkg::lp_id_t lp_mask;
   phold_pkg::sim_time_t gvt;
   logic rtn_vld;
   logic running;
   logic [63:0] total_cycles;
   logic disp_vld;
   phold_pkg::lp_id_t disp_lp;
   phold_pkg::sim_time_t disp_time;

   logic [15:0] rng_state;
   int value_errs;
   int other_errs;
   int cycle_cnt;

   phold_top uut (
      .clk             (clk),
      .rst_n           (rst_n),
      .sim_end         (sim_end),
      .num_init_events (num_init_events),
      .lp_mask         (lp_mask),
      .gvt             (gvt),
      .rtn_vld         (rtn_vld),
      .running         (running),
      .total_cycles    (total_cycles),
      .disp_vld        (disp_vld),
      .disp_lp         (disp_lp),
      .disp_time       (disp_time)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // one LFSR step per bit
   task automatic take_bits(input int n, output logic [15:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         rng_state = lfsr_step(rng_state);
         v = {v[14:0], rng_state[0]};
      end
   endtask

   task automatic value_error(input string name, input string expected,
                              input logic [63:0] actual);
      $display("[FAIL] t=%0t %s expected %s got %0d", $time, name, expected, actual);
      value_errs++;
   endtask

   task automatic finish_report();
      $display("errors: %0d (wrong values %0d, other %0d)",
               value_errs + other_errs, value_errs, other_errs);
      if (value_errs + other_errs == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   endtask

   // sim_end in 40..103, random mask
   task automatic pick_config(input logic [7:0] n_init);
      logic [15:0] v;
      take_bits(6, v);
      sim_end = 16'd40 + v;
      take_bits(6, v);
      lp_mask = v[5:0];
      num_init_events = n_init;
      $display("config: init events %0d, sim_end %0d, lp_mask %b",
               n_init, sim_end, lp_mask);
   endtask

   task automatic check_reset_values();
      if (rtn_vld !== 1'b0)
         value_error("rtn_vld", "0", rtn_vld);
      if (running !== 1'b0)
         value_error("running", "0", running);
      if (disp_vld !== 1'b0)
         value_error("disp_vld", "0", disp_vld);
      if (gvt !== '0)
         value_error("gvt", "0", gvt);
      if (total_cycles !== '0)
         value_error("total_cycles", "0", total_cycles);
   endtask

   // one run from IDLE to the end pulse, then one cycle past it
   task automatic run_once();
      int run_cyc;
      int disp_cnt;
      phold_pkg::sim_time_t last_gvt;
      run_cyc = 0;
      disp_cnt = 0;
      last_gvt = '0;
      do begin
         @(negedge clk);
         if (running) begin
            run_cyc++;
            if (gvt < last_gvt)
               value_error("gvt", $sformatf(">= %0d", last_gvt), gvt);
            last_gvt = gvt;
         end
         if (disp_vld) begin
            if ((disp_lp & ~lp_mask) != '0)
               value_error("disp_lp", $sformatf("inside mask %b", lp_mask), disp_lp);
            if (disp_time < gvt)
               value_error("disp_time", $sformatf(">= gvt %0d", gvt), disp_time);
            // initial events all sit at time 0
            if (disp_cnt < num_init_events && disp_time != '0)
               value_error("disp_time", "0", disp_time);
            disp_cnt++;
         end
      end while (rtn_vld !== 1'b1);

      if (gvt <= sim_end)
         value_error("gvt", $sformatf("> sim_end %0d", sim_end), gvt);
      if (running !== 1'b0)
         value_error("running", "0", running);
      if (total_cycles !== 64'(run_cyc))
         value_error("total_cycles", $sformatf("%0d", run_cyc), total_cycles);
      if (num_init_events == 0) begin
         if (gvt !== 16'hFFFF)
            value_error("gvt", "65535", gvt);
         if (disp_cnt != 0)
            value_error("disp_vld pulses", "0", disp_cnt);
      end else if (disp_cnt < num_init_events) begin
         value_error("disp_vld pulses", $sformatf(">= %0d", num_init_events), disp_cnt);
      end
      $display("run done: %0d running cycles, %0d dispatches, gvt %0d",
               run_cyc, disp_cnt, gvt);

      // end pulse lasts one cycle
      @(negedge clk);
      if (rtn_vld !== 1'b0)
         value_error("rtn_vld", "0", rtn_vld);
   endtask

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout: no run end within %0d cycles", TIMEOUT_CYCLES);
         other_errs++;
         finish_report();
      end
   end

   initial begin
      value_errs = 0;
      other_errs = 0;
      cycle_cnt = 0;
      rng_state = 16'd5962;
      rst_n = 1'b0;
      sim_end = '0;
      num_init_events = '0;
      lp_mask = '0;
      pick_config(8'd8);

      repeat (5) @(negedge clk);
      rst_n = 1'b1;
      check_reset_values();

      // first run
      run_once();

      // restart with new settings
      pick_config(8'd8);
      run_once();

      // nothing to simulate
      pick_config(8'd0);
      run_once();

      // restart after the empty run
      pick_config(8'd12);
      run_once();

      finish_report();
   end

endmodule

//--- verilog.f
+incdir+source
source/phold_pkg.sv
source/rr_arbiter.sv
source/event_queue.sv
source/lfsr_rng.sv
source/phold_core.sv
source/gvt_tracker.sv
source/phold_top.sv
tb/phold_tb.sv
